//--- source/rvCorePkg.sv
// RV32I core package with shared word types, opcode and state encodings, bus constants
package rvCorePkg;

   // Widths that carry a meaning
   typedef logic [31:0] word_t;   // Data word or instruction
   typedef logic [4:0]  regIdx_t; // Register file index
   typedef logic [2:0]  funct3_t; // Function field of the instruction
   typedef logic [3:0]  wmask_t;  // One bit per byte lane

   // Major opcodes, instr[6:2], low two bits are always 11 in RV32I
   typedef enum logic [4:0] {
      opLoad   = 5'b00000, // rd <- mem[rs1+Iimm]
      opAluImm = 5'b00100, // rd <- rs1 OP Iimm
      opAuipc  = 5'b00101, // rd <- PC + Uimm
      opStore  = 5'b01000, // mem[rs1+Simm] <- rs2
      opAluReg = 5'b01100, // rd <- rs1 OP rs2
      opLui    = 5'b01101, // rd <- Uimm
      opBranch = 5'b11000, // if (rs1 OP rs2) PC <- PC+Bimm
      opJalr   = 5'b11001, // rd <- PC+4, PC <- rs1+Iimm
      opJal    = 5'b11011  // rd <- PC+4, PC <- PC+Jimm
   } opcode_t;

   // Control FSM of the core
   typedef enum logic [1:0] {
      stFetch,     // Read strobe for the instruction
      stWaitInstr, // Waiting for the instruction word
      stExecute,   // Decode, ALU, PC update, memory strobe
      stWaitMem    // Waiting for load data or write completion
   } coreState_t;

   // Write masks with a name
   localparam wmask_t wmaskWord = 4'b1111; // All four lanes
   localparam wmask_t wmaskNone = 4'b0000; // No write

endpackage

//--- source/memBusIf.sv
// Memory bus of one requester, strobe and busy signalling toward the arbiter
interface memBusIf #(
   parameter int addrWidth = 16
);

   logic [addrWidth-1:0] addr;  // Byte address, meaningful bits only
   logic [31:0]          wdata; // Write data, lanes already placed
   logic [3:0]           wmask; // Nonzero for a single cycle per write
   logic                 rstrb; // One-cycle read request
   logic [31:0]          rdata; // Read data, valid once rbusy drops
   logic                 rbusy; // Read still in progress
   logic                 wbusy; // Write still in progress

   // Fetch unit or load/store unit side
   modport requester (
      output addr, wdata, wmask, rstrb,
      input  rdata, rbusy, wbusy
   );

   // Arbiter side
   modport arbiter (
      input  addr, wdata, wmask, rstrb,
      output rdata, rbusy, wbusy
   );

endinterface

//--- source/fetchUnit.sv
// Instruction fetch, word-aligned read on request and capture of the returned word
module fetchUnit import rvCorePkg::*; #(
   parameter int addrWidth = 16
) (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 fetchStart, // Pulse from the fetch state
   input  logic [addrWidth-1:0] pc,
   memBusIf.requester           bus,
   output logic                 instrValid,
   output word_t                instr
);

   logic pending; // Read issued, word not back yet

   // Fetch never writes
   assign bus.addr  = {pc[addrWidth-1:2], 2'b00};
   assign bus.rstrb = fetchStart;
   assign bus.wdata = '0;
   assign bus.wmask = wmaskNone;

   // First cycle after the strobe in which the memory is not busy
   assign instrValid = pending & ~bus.rbusy;

   always_ff @(posedge clk) begin
      if (!reset) begin
         pending <= 1'b0;
      end else if (fetchStart) begin
         pending <= 1'b1;
      end else if (instrValid) begin
         pending <= 1'b0;
      end
   end

   // Held through execute and waitMem
   always_ff @(posedge clk) begin
      if (instrValid) begin
         instr <= bus.rdata;
      end
   end

   // The core must not start a new fetch before the previous word came back
   fetchNotPending : assert property (@(posedge clk) disable iff (!reset)
      fetchStart |-> !pending)
      else $error("fetchStart while an instruction read is pending");

endmodule

//--- source/loadStoreUnit.sv
// Load/store unit that forms the address, places store lanes and extracts and extends load data
module loadStoreUnit import rvCorePkg::*; #(
   parameter int addrWidth = 16
) (
   input  logic       clk,
   input  logic       reset,
   input  logic       loadStart,  // Pulses in execute
   input  logic       storeStart, // Pulses in execute
   input  funct3_t    funct3,
   input  word_t      base,       // rs1
   input  word_t      offset,     // Iimm for loads, Simm for stores
   input  word_t      storeValue, // rs2
   memBusIf.requester bus,
   output logic       dataDone,
   output word_t      loadData
);

   word_t      addrSum;
   word_t      storeLanes;
   wmask_t     storeMask;
   logic       loadPending;
   logic       storePending;
   logic [1:0] accLow;    // Byte offset of the running access
   funct3_t    accFunct3; // Size and extension of the running access
   logic [15:0] loadHalf;
   logic [7:0]  loadByte;
   logic        loadSign;

   assign addrSum = base + offset;

   // Replicate narrow data so the selected lane always holds it
   always_comb begin
      case (funct3[1:0])
         2'b00: begin
            storeLanes = {4{storeValue[7:0]}};
            storeMask  = wmask_t'(4'b0001 << addrSum[1:0]); // One lane
         end
         2'b01: begin
            storeLanes = {2{storeValue[15:0]}};
            storeMask  = addrSum[1] ? 4'b1100 : 4'b0011;
         end
         default: begin
            storeLanes = storeValue;
            storeMask  = wmaskWord;
         end
      endcase
   end

   assign bus.addr  = addrSum[addrWidth-1:0];
   assign bus.wdata = storeLanes;
   assign bus.wmask = storeStart ? storeMask : wmaskNone; // Single-cycle mask
   assign bus.rstrb = loadStart;

   always_ff @(posedge clk) begin
      if (!reset) begin
         loadPending  <= 1'b0;
         storePending <= 1'b0;
      end else begin
         loadPending  <= loadStart | (loadPending & bus.rbusy);
         storePending <= storeStart | (storePending & bus.wbusy);
      end
   end

   // Access attributes kept for the data return
   always_ff @(posedge clk) begin
      if (loadStart | storeStart) begin
         accLow    <= addrSum[1:0];
         accFunct3 <= funct3;
      end
   end

   assign dataDone = (loadPending & ~bus.rbusy) | (storePending & ~bus.wbusy);

   // Pick the lane, then sign or zero extend
   assign loadHalf = accLow[1] ? bus.rdata[31:16] : bus.rdata[15:0];
   assign loadByte = accLow[0] ? loadHalf[15:8] : loadHalf[7:0];
   assign loadSign = ~accFunct3[2] & (accFunct3[0] ? loadHalf[15] : loadByte[7]);

   always_comb begin
      case (accFunct3[1:0])
         2'b00:   loadData = {{24{loadSign}}, loadByte};
         2'b01:   loadData = {{16{loadSign}}, loadHalf};
         default: loadData = bus.rdata;
      endcase
   end

   // Halfwords on even addresses, words on multiples of four
   alignedAccess : assert property (@(posedge clk) disable iff (!reset)
      (loadStart | storeStart) |->
         (funct3[1:0] == 2'b00) ||
         (funct3[1:0] == 2'b01 && !addrSum[0]) ||
         (funct3[1:0] == 2'b10 && addrSum[1:0] == 2'b00))
      else $error("Misaligned access at %h", addrSum);

endmodule

//--- source/busArbiter.sv
// Bus arbiter, data side has priority, read data and busy routed back to the read owner
module busArbiter import rvCorePkg::*; #(
   parameter int addrWidth = 16
) (
   input  logic     clk,
   input  logic     reset,
   memBusIf.arbiter fetchBus,
   memBusIf.arbiter dataBus,
   output word_t    memAddr,
   output word_t    memWdata,
   output wmask_t   memWmask,
   output logic     memRstrb,
   input  word_t    memRdata,
   input  logic     memRbusy,
   input  logic     memWbusy
);

   localparam logic [31-addrWidth:0] addrPad = '0;

   logic dataSel;    // Data side requests this cycle
   logic ownerData;  // Outstanding read belongs to the data side
   logic readActive; // A read is still in flight

   assign dataSel  = dataBus.rstrb | (|dataBus.wmask);
   assign memAddr  = {addrPad, dataSel ? dataBus.addr : fetchBus.addr};
   assign memWdata = dataSel ? dataBus.wdata : fetchBus.wdata;
   assign memWmask = dataSel ? dataBus.wmask : fetchBus.wmask;
   assign memRstrb = dataBus.rstrb | fetchBus.rstrb;

   always_ff @(posedge clk) begin
      if (!reset) begin
         ownerData  <= 1'b0;
         readActive <= 1'b0;
      end else begin
         if (memRstrb) ownerData <= dataBus.rstrb; // Data wins a tie
         readActive <= memRstrb | (readActive & memRbusy);
      end
   end

   // Only the owner sees the data, the other side stays busy until the read ends
   assign fetchBus.rdata = ownerData ? '0 : memRdata;
   assign dataBus.rdata  = ownerData ? memRdata : '0;
   assign fetchBus.rbusy = memRbusy | (readActive & ownerData);
   assign dataBus.rbusy  = memRbusy | (readActive & ~ownerData);
   assign fetchBus.wbusy = memWbusy;
   assign dataBus.wbusy  = memWbusy;

   singleStrobe : assert property (@(posedge clk) disable iff (!reset)
      !(fetchBus.rstrb && dataBus.rstrb))
      else $error("Fetch and data read strobes in the same cycle");

endmodule

//--- source/aluUnit.sv
// Integer ALU with one subtractor for compares, one shared shifter, branch condition
module aluUnit import rvCorePkg::*; (
   input  word_t instr,
   input  word_t aluIn1,
   input  word_t aluIn2,
   output word_t aluOut,
   output word_t aluPlus,
   output logic  takeBranch
);

   logic [7:0]         funct3Is;   // One-hot funct3
   logic [32:0]        aluMinus;   // aluIn1 - aluIn2 with borrow out
   logic               lt;
   logic               ltu;
   logic               eq;
   word_t              aluIn1Rev;
   word_t              shiftIn;
   logic signed [32:0] shiftExt;   // Extra top bit carries the SRA sign
   logic signed [32:0] shiftWide;
   word_t              shiftRight;
   word_t              shiftLeft;

   assign funct3Is = 8'b0000_0001 << instr[14:12];

   assign aluPlus  = aluIn1 + aluIn2;
   assign aluMinus = {1'b1, ~aluIn2} + {1'b0, aluIn1} + 33'd1;
   assign ltu      = aluMinus[32];                                   // Borrow
   assign lt       = (aluIn1[31] ^ aluIn2[31]) ? aluIn1[31] : ltu;  // Signs differ
   assign eq       = (aluMinus[31:0] == 32'd0);

   // Left shift = reverse, shift right, reverse back
   assign aluIn1Rev  = {<<{aluIn1}};
   assign shiftIn    = funct3Is[1] ? aluIn1Rev : aluIn1;
   assign shiftExt   = {instr[30] & aluIn1[31], shiftIn}; // instr[30] set for SRA
   assign shiftWide  = shiftExt >>> aluIn2[4:0];
   assign shiftRight = shiftWide[31:0];
   assign shiftLeft  = {<<{shiftRight}};

   always_comb begin
      aluOut = '0;
      // SUB only for register ops, ADDI reuses bit 30 as immediate
      if (funct3Is[0]) aluOut |= (instr[30] & instr[5]) ? aluMinus[31:0] : aluPlus;
      if (funct3Is[1]) aluOut |= shiftLeft;
      if (funct3Is[2]) aluOut |= {31'd0, lt};
      if (funct3Is[3]) aluOut |= {31'd0, ltu};
      if (funct3Is[4]) aluOut |= aluIn1 ^ aluIn2;
      if (funct3Is[5]) aluOut |= shiftRight;      // SRL and SRA
      if (funct3Is[6]) aluOut |= aluIn1 | aluIn2;
      if (funct3Is[7]) aluOut |= aluIn1 & aluIn2;
   end

   // Branch conditions, funct3 2 and 3 are not branches
   assign takeBranch = (funct3Is[0] &  eq)  | // BEQ
                       (funct3Is[1] & ~eq)  | // BNE
                       (funct3Is[4] &  lt)  | // BLT
                       (funct3Is[5] & ~lt)  | // BGE
                       (funct3Is[6] &  ltu) | // BLTU
                       (funct3Is[7] & ~ltu);  // BGEU

endmodule

//--- source/rvCore.sv
// Multicycle RV32I core with decoder, register file, PC and control FSM over a shared bus
module rvCore import rvCorePkg::*; #(
   parameter word_t resetAddr = 32'h0000_0000,
   parameter int    addrWidth = 16
) (
   input  logic   clk,
   input  logic   reset,
   output word_t  memAddr,
   output word_t  memWdata,
   output wmask_t memWmask,
   input  word_t  memRdata,
   output logic   memRstrb,
   input  logic   memRbusy,
   input  logic   memWbusy
);

   localparam logic [31-addrWidth:0] addrPad = '0;

   memBusIf #(.addrWidth(addrWidth)) fetchBus ();
   memBusIf #(.addrWidth(addrWidth)) dataBus ();

   coreState_t           state;
   logic [addrWidth-1:0] pc;
   logic [addrWidth-1:0] pcPlus4;
   logic [addrWidth-1:0] pcPlusImm; // Branch, JAL and AUIPC target
   logic [addrWidth-1:0] pcNext;
   logic                 memPending; // waitMem holds a real access
   word_t                instr;
   logic                 instrValid;
   logic                 fetchStart;
   logic                 loadStart;
   logic                 storeStart;
   logic                 dataDone;
   word_t                loadData;
   opcode_t              opcode;
   regIdx_t              rdIdx;
   regIdx_t              rs1Idx;
   regIdx_t              rs2Idx;
   funct3_t              funct3;
   word_t                uImm;
   word_t                iImm;
   word_t                sImm;
   word_t                bImm;
   word_t                jImm;
   logic                 isLoad;
   logic                 isStore;
   logic                 isBranch;
   word_t                regFile [32];
   word_t                rs1;
   word_t                rs2;
   word_t                aluIn2;
   word_t                aluOut;
   word_t                aluPlus;
   logic                 takeBranch;
   word_t                writeData;
   logic                 regWrite;

   // Decoder
   assign opcode   = opcode_t'(instr[6:2]);
   assign rdIdx    = instr[11:7];
   assign rs1Idx   = instr[19:15];
   assign rs2Idx   = instr[24:20];
   assign funct3   = instr[14:12];
   assign uImm     = {instr[31:12], 12'd0};
   assign iImm     = {{21{instr[31]}}, instr[30:20]};
   assign sImm     = {{21{instr[31]}}, instr[30:25], instr[11:7]};
   assign bImm     = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
   assign jImm     = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
   assign isLoad   = (opcode == opLoad);
   assign isStore  = (opcode == opStore);
   assign isBranch = (opcode == opBranch);

   // Register file, x0 reads as zero and is never written
   assign rs1 = (rs1Idx == 5'd0) ? '0 : regFile[rs1Idx];
   assign rs2 = (rs2Idx == 5'd0) ? '0 : regFile[rs2Idx];

   always_ff @(posedge clk) begin
      if (regWrite) regFile[rdIdx] <= writeData;
   end

   assign aluIn2 = (opcode == opAluReg || isBranch) ? rs2 : iImm;

   aluUnit aluUnit_i (
      .instr(instr), .aluIn1(rs1), .aluIn2(aluIn2),
      .aluOut(aluOut), .aluPlus(aluPlus), .takeBranch(takeBranch)
   );

   // PC adders
   assign pcPlus4   = pc + addrWidth'(4);
   assign pcPlusImm = pc + ((opcode == opJal)   ? jImm[addrWidth-1:0] :
                            (opcode == opAuipc) ? uImm[addrWidth-1:0] :
                                                  bImm[addrWidth-1:0]);
   assign pcNext = (opcode == opJalr) ? {aluPlus[addrWidth-1:1], 1'b0} :
                   ((opcode == opJal) || (isBranch && takeBranch)) ? pcPlusImm :
                   pcPlus4;

   always_comb begin
      case (opcode)
         opLui:            writeData = uImm;
         opAuipc:          writeData = {addrPad, pcPlusImm};
         opJal, opJalr:    writeData = {addrPad, pcPlus4};   // Return address
         opLoad:           writeData = loadData;
         opAluImm, opAluReg: writeData = aluOut;
         default:          writeData = '0;
      endcase
   end

   // Loads write back on dataDone, everything else in execute
   assign regWrite = (rdIdx != 5'd0) &&
                     (((state == stExecute) && !(isBranch || isStore || isLoad)) ||
                      ((state == stWaitMem) && isLoad && dataDone));

   assign fetchStart = (state == stFetch);
   assign loadStart  = (state == stExecute) & isLoad;
   assign storeStart = (state == stExecute) & isStore;

   // Reset lands in waitMem with nothing pending, so the first strobe comes a cycle later
   always_ff @(posedge clk) begin
      if (!reset) begin
         state      <= stWaitMem;
         pc         <= resetAddr[addrWidth-1:0];
         memPending <= 1'b0;
      end else begin
         case (state)
            stFetch: state <= stWaitInstr;
            stWaitInstr: begin
               if (instrValid) state <= stExecute;
            end
            stExecute: begin
               pc         <= pcNext;
               memPending <= isLoad | isStore;
               state      <= (isLoad | isStore) ? stWaitMem : stFetch;
            end
            default: begin // stWaitMem
               if (dataDone | ~memPending) begin
                  state      <= stFetch;
                  memPending <= 1'b0;
               end
            end
         endcase
      end
   end

   fetchUnit #(.addrWidth(addrWidth)) fetchUnit_i (
      .clk(clk), .reset(reset), .fetchStart(fetchStart), .pc(pc),
      .bus(fetchBus), .instrValid(instrValid), .instr(instr)
   );

   loadStoreUnit #(.addrWidth(addrWidth)) loadStoreUnit_i (
      .clk(clk), .reset(reset), .loadStart(loadStart), .storeStart(storeStart),
      .funct3(funct3), .base(rs1), .offset(isStore ? sImm : iImm), .storeValue(rs2),
      .bus(dataBus), .dataDone(dataDone), .loadData(loadData)
   );

   busArbiter #(.addrWidth(addrWidth)) busArbiter_i (
      .clk(clk), .reset(reset), .fetchBus(fetchBus), .dataBus(dataBus),
      .memAddr(memAddr), .memWdata(memWdata), .memWmask(memWmask), .memRstrb(memRstrb),
      .memRdata(memRdata), .memRbusy(memRbusy), .memWbusy(memWbusy)
   );

endmodule

//--- verification/tbMemory.sv
// Test memory model, RV32I program image and random busy stretching of reads and writes
module tbMemory import rvCorePkg::*; (
   input  logic   clk,
   input  logic   reset,
   input  word_t  memAddr,
   input  word_t  memWdata,
   input  wmask_t memWmask,
   input  logic   memRstrb,
   output word_t  memRdata,
   output logic   memRbusy,
   output logic   memWbusy
);

   word_t  mem [256];
   word_t  rdWord;
   int     rCount;   // Busy cycles left on the running read
   int     wCount;   // Busy cycles left on the running write
   int     loadPos;  // Next program word
   integer seed;

   // Instruction encoders, RV32I field layout
   function automatic word_t encR(int f7, int rs2, int rs1, int f3, int rd);
      return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
   endfunction

   function automatic word_t encI(int imm, int rs1, int f3, int rd, int op);
      return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
   endfunction

   function automatic word_t encS(int imm, int rs2, int rs1, int f3);
      return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'b0100011};
   endfunction

   function automatic word_t encB(int imm, int rs2, int rs1, int f3);
      return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
   endfunction

   function automatic word_t encU(int imm, int rd, int op);
      return {imm[19:0], rd[4:0], op[6:0]};
   endfunction

   function automatic word_t encJ(int imm, int rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
   endfunction

   task automatic placeWord(input word_t w);
      mem[loadPos] = w;
      loadPos++;
   endtask

   initial begin
      seed     = 58;
      memRdata = '0;
      memRbusy = 1'b0;
      memWbusy = 1'b0;
      rdWord   = '0;
      rCount   = 0;
      wCount   = 0;
      loadPos  = 0;
      for (int i = 0; i < 256; i++) mem[i] = 32'h0BAD_0000 | i; // Unused words
      placeWord(encI(100, 0, 0, 1, 'h13));    // addi x1, x0, 100
      placeWord(encI(-7, 0, 0, 2, 'h13));     // addi x2, x0, -7
      placeWord(encR(0, 2, 1, 0, 3));         // add x3
      placeWord(encS('h200, 3, 0, 2));
      placeWord(encR('h20, 2, 1, 0, 4));      // sub x4
      placeWord(encS('h204, 4, 0, 2));
      placeWord(encI(3, 1, 1, 5, 'h13));      // slli x5, x1, 3
      placeWord(encS('h208, 5, 0, 2));
      placeWord(encI('h401, 2, 5, 6, 'h13));  // srai x6, x2, 1
      placeWord(encS('h20C, 6, 0, 2));
      placeWord(encI(28, 2, 5, 7, 'h13));     // srli x7, x2, 28
      placeWord(encS('h210, 7, 0, 2));
      placeWord(encR(0, 1, 2, 2, 8));         // slt x8, x2, x1
      placeWord(encR(0, 1, 2, 3, 9));         // sltu x9, x2, x1
      placeWord(encS('h214, 8, 0, 2));
      placeWord(encS('h218, 9, 0, 2));
      placeWord(encR(0, 2, 1, 4, 10));        // xor
      placeWord(encS('h21C, 10, 0, 2));
      placeWord(encR(0, 2, 1, 6, 11));        // or
      placeWord(encS('h220, 11, 0, 2));
      placeWord(encR(0, 2, 1, 7, 12));        // and
      placeWord(encS('h224, 12, 0, 2));
      placeWord(encU('h12345, 13, 'h37));     // lui
      placeWord(encS('h228, 13, 0, 2));
      placeWord(encU(1, 14, 'h17));           // auipc at 0x60
      placeWord(encS('h22C, 14, 0, 2));
      placeWord(encU('h87654, 15, 'h37));
      placeWord(encI('h321, 15, 0, 15, 'h13)); // x15 = 0x87654321
      placeWord(encS('h240, 15, 0, 0));       // sb at all four offsets
      placeWord(encS('h241, 15, 0, 0));
      placeWord(encS('h242, 15, 0, 0));
      placeWord(encS('h243, 15, 0, 0));
      placeWord(encS('h244, 15, 0, 1));       // sh low and high half
      placeWord(encS('h246, 15, 0, 1));
      placeWord(encI('h302, 0, 0, 16, 'h03)); // lb
      placeWord(encS('h248, 16, 0, 2));
      placeWord(encI('h302, 0, 4, 17, 'h03)); // lbu
      placeWord(encS('h24C, 17, 0, 2));
      placeWord(encI('h302, 0, 1, 18, 'h03)); // lh
      placeWord(encS('h250, 18, 0, 2));
      placeWord(encI('h302, 0, 5, 19, 'h03)); // lhu
      placeWord(encS('h254, 19, 0, 2));
      placeWord(encI('h300, 0, 2, 20, 'h03)); // lw
      placeWord(encS('h258, 20, 0, 2));
      placeWord(encB(8, 1, 1, 0));            // beq taken
      placeWord(encS('h2F0, 0, 0, 2));        // Skipped
      placeWord(encB(8, 1, 1, 1));            // bne not taken
      placeWord(encS('h260, 1, 0, 2));
      placeWord(encB(8, 1, 2, 4));            // blt taken
      placeWord(encS('h2F0, 0, 0, 2));
      placeWord(encB(8, 1, 2, 7));            // bgeu taken
      placeWord(encS('h2F0, 0, 0, 2));
      placeWord(encJ(8, 22));                 // jal x22 at 0xD0
      placeWord(encS('h2F0, 0, 0, 2));
      placeWord(encS('h264, 22, 0, 2));
      placeWord(encI(232, 0, 0, 25, 'h13));   // x25 = 0xE8
      placeWord(encI(0, 25, 0, 23, 'h67));    // jalr x23 at 0xE0
      placeWord(encS('h2F0, 0, 0, 2));
      placeWord(encS('h268, 23, 0, 2));
      placeWord(encJ(0, 0));                  // Spin
      mem[192] = 32'h80FF_7F01;                // Load source at 0x300
   end

   always @(posedge clk) begin
      if (!reset) begin
         rCount = 0;
         wCount = 0;
      end else begin
         if (rCount > 0) rCount = rCount - 1;
         if (wCount > 0) wCount = wCount - 1;
         if (memRstrb) begin
            rdWord = mem[memAddr[9:2]];
            rCount = $unsigned($random(seed)) % 4;
         end
         if (|memWmask) begin
            for (int b = 0; b < 4; b++) begin
               if (memWmask[b]) mem[memAddr[9:2]][8*b +: 8] = memWdata[8*b +: 8];
            end
            wCount = $unsigned($random(seed)) % 4;
         end
      end
      #1;
      memRdata = rdWord;
      memRbusy = (rCount != 0);
      memWbusy = (wCount != 0);
   end

endmodule

//--- verification/rvCoreTb.sv
// Testbench of the RV32I core, program run checked against a table of expected bus writes
module rvCoreTb import rvCorePkg::*; ();

   localparam word_t resetAddr = 32'h0000_0000;
   localparam int    maxStores = 32;
   // About 60 instructions at up to 16 cycles each under busy stretching, 4x margin
   localparam int    watchdogCycles = 4000;

   logic   clk;
   logic   reset;
   word_t  memAddr;
   word_t  memWdata;
   word_t  memRdata;
   wmask_t memWmask;
   logic   memRstrb;
   logic   memRbusy;
   logic   memWbusy;

   word_t  expAddr [maxStores];
   word_t  expData [maxStores];
   wmask_t expMask [maxStores];
   word_t  expAddrNow;
   word_t  expDataNow;
   wmask_t expMaskNow;
   int     numStores;
   int     storeIdx;
   int     mismatchCount = 0;
   int     protocolCount = 0;
   logic   wasReset = 1'b0;  // Reset was low at the previous edge
   logic   seenStrobe;
   logic   readOut;          // Read strobed and not yet ended
   logic   writeOut;         // Write issued and not yet complete

   rvCore #(.resetAddr(resetAddr), .addrWidth(16)) rvCore_i (
      .clk(clk), .reset(reset), .memAddr(memAddr), .memWdata(memWdata),
      .memWmask(memWmask), .memRdata(memRdata), .memRstrb(memRstrb),
      .memRbusy(memRbusy), .memWbusy(memWbusy)
   );

   tbMemory memory_i (
      .clk(clk), .reset(reset), .memAddr(memAddr), .memWdata(memWdata),
      .memWmask(memWmask), .memRstrb(memRstrb), .memRdata(memRdata),
      .memRbusy(memRbusy), .memWbusy(memWbusy)
   );

   task automatic expectStore(input word_t a, input word_t d, input wmask_t m);
      expAddr[numStores] = a;
      expData[numStores] = d;
      expMask[numStores] = m;
      numStores++;
   endtask

   assign expAddrNow = expAddr[storeIdx % maxStores];
   assign expDataNow = expData[storeIdx % maxStores];
   assign expMaskNow = expMask[storeIdx % maxStores];

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk) begin
      wasReset <= !reset;
      if (!reset) begin
         storeIdx   <= 0;
         seenStrobe <= 1'b0;
         readOut    <= 1'b0;
         writeOut   <= 1'b0;
      end else begin
         if (|memWmask) storeIdx <= storeIdx + 1;
         if (memRstrb) seenStrobe <= 1'b1;
         readOut  <= memRstrb | (readOut & memRbusy);
         writeOut <= (|memWmask) | (writeOut & memWbusy);
      end
   end

   storeAddrOk : assert property (@(posedge clk) disable iff (!reset)
      (|memWmask) |-> memAddr == expAddrNow)
      else begin
         $display("Mismatch memAddr got %h expected %h", $sampled(memAddr), $sampled(expAddrNow));
         mismatchCount++;
      end

   storeDataOk : assert property (@(posedge clk) disable iff (!reset)
      (|memWmask) |-> memWdata == expDataNow)
      else begin
         $display("Mismatch memWdata got %h expected %h", $sampled(memWdata),
                  $sampled(expDataNow));
         mismatchCount++;
      end

   storeMaskOk : assert property (@(posedge clk) disable iff (!reset)
      (|memWmask) |-> memWmask == expMaskNow)
      else begin
         $display("Mismatch memWmask got %h expected %h", $sampled(memWmask),
                  $sampled(expMaskNow));
         mismatchCount++;
      end

   noExtraStore : assert property (@(posedge clk) disable iff (!reset)
      (|memWmask) |-> storeIdx < numStores)
      else begin
         $display("A bus write came after all expected stores were seen");
         protocolCount++;
      end

   // Covers the reset cycles and the first cycle after reset
   quietInReset : assert property (@(posedge clk)
      wasReset |-> !memRstrb && memWmask == wmaskNone)
      else begin
         $display("Strobe or write mask seen during or right after reset");
         protocolCount++;
      end

   firstFetch : assert property (@(posedge clk) disable iff (!reset)
      (memRstrb && !seenStrobe) |-> memAddr == resetAddr)
      else begin
         $display("Mismatch memAddr got %h expected %h", $sampled(memAddr), resetAddr);
         mismatchCount++;
      end

   oneOutstanding : assert property (@(posedge clk) disable iff (!reset)
      (memRstrb || (|memWmask)) |-> !(readOut || writeOut))
      else begin
         $display("New bus access started while another was outstanding");
         protocolCount++;
      end

   initial begin
      reset     = 1'b0;
      numStores = 0;
      expectStore(32'h200, 32'h0000_005D, 4'hF); // 100 + -7
      expectStore(32'h204, 32'h0000_006B, 4'hF); // 100 - -7
      expectStore(32'h208, 32'h0000_0320, 4'hF); // 100 << 3
      expectStore(32'h20C, 32'hFFFF_FFFC, 4'hF); // -7 >>> 1
      expectStore(32'h210, 32'h0000_000F, 4'hF); // Logical >> 28
      expectStore(32'h214, 32'h0000_0001, 4'hF); // -7 < 100 signed
      expectStore(32'h218, 32'h0000_0000, 4'hF); // Not below unsigned
      expectStore(32'h21C, 32'hFFFF_FF9D, 4'hF);
      expectStore(32'h220, 32'hFFFF_FFFD, 4'hF);
      expectStore(32'h224, 32'h0000_0060, 4'hF);
      expectStore(32'h228, 32'h1234_5000, 4'hF);
      expectStore(32'h22C, 32'h0000_1060, 4'hF); // 0x60 + 0x1000
      expectStore(32'h240, 32'h2121_2121, 4'h1); // Byte replicated on all lanes
      expectStore(32'h241, 32'h2121_2121, 4'h2);
      expectStore(32'h242, 32'h2121_2121, 4'h4);
      expectStore(32'h243, 32'h2121_2121, 4'h8);
      expectStore(32'h244, 32'h4321_4321, 4'h3);
      expectStore(32'h246, 32'h4321_4321, 4'hC);
      expectStore(32'h248, 32'hFFFF_FFFF, 4'hF); // lb of 0xFF
      expectStore(32'h24C, 32'h0000_00FF, 4'hF);
      expectStore(32'h250, 32'hFFFF_80FF, 4'hF);
      expectStore(32'h254, 32'h0000_80FF, 4'hF);
      expectStore(32'h258, 32'h80FF_7F01, 4'hF);
      expectStore(32'h260, 32'h0000_0064, 4'hF); // Fall-through of bne
      expectStore(32'h264, 32'h0000_00D4, 4'hF); // Link of jal
      expectStore(32'h268, 32'h0000_00E4, 4'hF); // Link of jalr
      repeat (8) @(posedge clk);
      #1 reset = 1'b1;
      while (storeIdx < numStores) @(posedge clk);
      repeat (20) @(posedge clk);
      $display("Stores %0d of %0d, mismatches %0d, other errors %0d",
               storeIdx, numStores, mismatchCount, protocolCount);
      if (mismatchCount == 0 && protocolCount == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   initial begin
      repeat (watchdogCycles) @(posedge clk);
      $display("Timeout, the program did not reach its last store");
      $display("Stores %0d of %0d, mismatches %0d, other errors %0d",
               storeIdx, numStores, mismatchCount, protocolCount);
      $display("TEST FAILED");
      $finish;
   end

endmodule

//--- verilog.f
source/rvCorePkg.sv
source/memBusIf.sv
source/fetchUnit.sv
source/loadStoreUnit.sv
source/busArbiter.sv
source/aluUnit.sv
source/rvCore.sv
verification/tbMemory.sv
verification/rvCoreTb.sv

//--- run.sh
#!/bin/sh
# Build and run the core testbench with Verilator, result taken from the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module rvCoreTb \
   -f verilog.f -o rvCoreSim

./obj_dir/rvCoreSim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST OK" sim.log; then
   exit 0
fi
exit 1
